//--- Bender.yml
package:
  name: z80_bridge

sources:
  - include_dirs:
      - include
    files:
      - hdl/z80_bus_pkg.sv
      - hdl/gpu_mem_pkg.sv
      - hdl/bridge_ifs.sv
      - hdl/z80_cycle_ctrl.sv
      - hdl/gpu_mem_port.sv
      - hdl/kbd_io_port.sv
      - hdl/gpu_ram.sv
      - hdl/z80_bridge_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/z80_bridge_props.sv
      - verif/z80_bridge_tb.sv

//--- build.f
+incdir+include
hdl/z80_bus_pkg.sv
hdl/gpu_mem_pkg.sv
hdl/bridge_ifs.sv
hdl/z80_cycle_ctrl.sv
hdl/gpu_mem_port.sv
hdl/kbd_io_port.sv
hdl/gpu_ram.sv
hdl/z80_bridge_top.sv
verif/z80_bridge_props.sv
verif/z80_bridge_tb.sv

//--- hdl/bridge_ifs.sv
// ********************
// Wishbone classic to GPU RAM
// ********************
interface gpu_wb_if;
   import gpu_mem_pkg::*;

   logic      cyc;                    // Bus cycle in progress
   logic      stb;                    // Transfer strobe
   logic      we;                     // High for write
   gpu_addr_t adr;
   gpu_data_t dat_w;
   gpu_data_t dat_r;
   logic      ack;                    // One per strobe

   modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);
   modport slave  (input cyc, stb, we, adr, dat_w, output dat_r, ack);
endinterface

// Controller to memory port, one request in flight
interface mem_req_if;
   import gpu_mem_pkg::*;

   logic      req;                    // Single cycle request pulse
   logic      we;
   gpu_addr_t addr;
   gpu_data_t wdata;
   logic      done;                   // Single cycle completion pulse
   gpu_data_t rdata;                  // Valid with done on reads

   modport ctrl (output req, we, addr, wdata, input done, rdata);
   modport port (input req, we, addr, wdata, output done, rdata);
endinterface

// Controller to keyboard registers
interface kbd_if;
   import z80_bus_pkg::*;

   logic       rd_data_done;          // Data port read finished
   logic       ctrl_wr;               // Control port write strobe
   logic [7:0] ctrl_wdata;
   logic       inta_end;              // Acknowledge finished
   logic [7:0] char;                  // Last character
   kbd_stat_t  stat;
   logic       int_pending;           // Request level toward the host

   modport ctrl (output rd_data_done, ctrl_wr, ctrl_wdata, inta_end,
                 input char, stat, int_pending);
   modport port (input rd_data_done, ctrl_wr, ctrl_wdata, inta_end,
                 output char, stat, int_pending);
endinterface

//--- hdl/gpu_mem_pkg.sv
package gpu_mem_pkg;

   // ********************
   // GPU memory side
   // ********************

   typedef logic [18:0] gpu_addr_t;   // Byte address inside the 512 KB window
   typedef logic [7:0]  gpu_data_t;   // GPU RAM is byte wide

   // Where a window read gets its byte from
   typedef enum logic [1:0] {
      SRC_RAM     = 2'd0,             // Real RAM through Wishbone
      SRC_BANK_ID = 2'd1,             // Bank identification block
      SRC_FILL    = 2'd2              // Unpopulated space reads FF
   } rd_src_e;

endpackage

//--- hdl/gpu_mem_port.sv
`include "z80_bridge_defs.svh"

module gpu_mem_port (
   input  logic     GPU_CLK,
   input  logic     arst_n,
   mem_req_if.port  req,
   gpu_wb_if.master wb
);
   import gpu_mem_pkg::*;

   rd_src_e   src;                    // Classification of the current request
   logic      cyc_q;                  // Wishbone transfer open
   logic      done_q;
   gpu_data_t rdata_q;
   gpu_data_t bank_id [16];           // Bank identification bytes

   // "GPU EP4CE6" tagged with board id and terminator
   assign bank_id = '{8'h09, 8'h03, 8'h47, 8'h50, 8'h55, 8'h20, 8'h45, 8'h50,
                      8'h34, 8'h43, 8'h45, 8'h36, 8'h00, 8'hFF, 8'hFF, 8'hFF};

   // ********************
   // Range checks
   // ********************
   always_comb begin
      if ((req.addr >> `MEM_SIZE_BITS) == '0)
         src = SRC_RAM;
      else if ({`MEMORY_RANGE, req.addr[18:4]} == `BANK_ID_ADDR)
         src = SRC_BANK_ID;
      else
         src = SRC_FILL;
   end

   assign wb.cyc     = cyc_q;
   assign wb.stb     = cyc_q;         // Classic cycle, one strobe per transfer
   assign req.done   = done_q;
   assign req.rdata  = rdata_q;

   // ********************
   // Wishbone master
   // ********************
   always_ff @(posedge GPU_CLK or negedge arst_n) begin
      if (!arst_n) begin
         cyc_q  <= 1'b0;
         done_q <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (cyc_q) begin
            if (wb.ack) begin
               cyc_q  <= 1'b0;        // Drop in the cycle after ack
               done_q <= 1'b1;
            end
         end else if (req.req) begin
            if (src == SRC_RAM)
               cyc_q  <= 1'b1;
            else
               done_q <= 1'b1;        // Answer locally, writes vanish
         end
      end
   end

   always_ff @(posedge GPU_CLK) begin
      if (req.req && !cyc_q) begin
         wb.adr   <= req.addr;        // Held until ack
         wb.we    <= req.we;
         wb.dat_w <= req.wdata;
         rdata_q  <= (src == SRC_BANK_ID) ? bank_id[req.addr[3:0]] : 8'hFF;
      end else if (cyc_q && wb.ack) begin
         rdata_q  <= wb.dat_r;
      end
   end

endmodule

//--- hdl/gpu_ram.sv
`include "z80_bridge_defs.svh"

module gpu_ram (
   input  logic    GPU_CLK,
   input  logic    arst_n,
   gpu_wb_if.slave wb
);
   import gpu_mem_pkg::*;

   gpu_data_t mem [2**`MEM_SIZE_BITS];   // Populated GPU RAM
   logic      ack_q;
   logic      access;                 // New strobe not yet answered

   assign access = wb.cyc && wb.stb && !ack_q;

   // ********************
   // Acknowledge
   // ********************
   always_ff @(posedge GPU_CLK or negedge arst_n) begin
      if (!arst_n)
         ack_q <= 1'b0;
      else
         ack_q <= access;             // One ack per strobe
   end

   always_ff @(posedge GPU_CLK) begin
      if (access) begin
         if (wb.we)
            mem[wb.adr[`MEM_SIZE_BITS-1:0]] <= wb.dat_w;
         wb.dat_r <= mem[wb.adr[`MEM_SIZE_BITS-1:0]];
      end
   end

   assign wb.ack = ack_q;

endmodule

//--- hdl/kbd_io_port.sv
module kbd_io_port (
   input  logic       GPU_CLK,
   input  logic       arst_n,
   input  logic       ps2_rdy,        // Keyboard byte ready
   input  logic [7:0] ps2_dat,
   input  logic       iei,            // Daisy chain in
   output logic       int_req,
   output logic       ieo,            // Daisy chain out
   kbd_if.port        kbd
);
   import z80_bus_pkg::*;

   logic       ps2_prev;
   logic       ps2_strobe;            // Rising edge of ps2_rdy
   logic [7:0] char_q;
   logic       avail_q;
   logic       int_en_q;              // Interrupt mode from control port
   logic       pend_q;                // Internal request flag

   assign ps2_strobe = ps2_rdy && !ps2_prev;

   // ********************
   // Registers
   // ********************
   always_ff @(posedge GPU_CLK or negedge arst_n) begin
      if (!arst_n) begin
         ps2_prev <= 1'b0;
         char_q   <= '0;
         avail_q  <= 1'b0;
         int_en_q <= 1'b0;            // Polled after reset
         pend_q   <= 1'b0;
         int_req  <= 1'b0;
      end else begin
         ps2_prev <= ps2_rdy;
         if (kbd.ctrl_wr)
            int_en_q <= kbd.ctrl_wdata[0];
         if (ps2_strobe) begin
            char_q  <= ps2_dat;
            avail_q <= 1'b1;
         end else if (kbd.rd_data_done) begin
            char_q  <= '0;            // Consumed by the host
            avail_q <= 1'b0;
         end
         // Acknowledge closes the request
         if (kbd.inta_end) begin
            pend_q  <= 1'b0;
            int_req <= 1'b0;
         end else if (int_en_q && pend_q && iei) begin
            int_req <= 1'b1;          // Upstream allows us
         end
         if (ps2_strobe && int_en_q)
            pend_q <= 1'b1;
      end
   end

   assign ieo = iei && !pend_q;       // Block downstream while pending

   assign kbd.char        = char_q;
   assign kbd.stat        = '{rsvd: '0, int_en: int_en_q, avail: avail_q};
   assign kbd.int_pending = int_req;

endmodule

//--- hdl/z80_bridge_top.sv
module z80_bridge_top (
   input  logic        GPU_CLK,
   input  logic        arst_n,
   input  logic        z80_m1_n,
   input  logic        z80_mreq_n,
   input  logic        z80_iorq_n,
   input  logic        z80_rd_n,
   input  logic        z80_wr_n,
   input  logic        z80_iei,       // Interrupt daisy chain in
   input  logic        ps2_rdy,
   input  logic [21:0] z80_addr,
   input  logic [7:0]  z80_wdata,
   input  logic [7:0]  ps2_dat,
   output logic [7:0]  z80_rdata,
   output logic        z80_rdata_ena,
   output logic        z80_245_dir,
   output logic        z80_245_oe_n,
   output logic        z80_wait_n,
   output logic        z80_int_req,
   output logic        z80_ieo
);

   // ********************
   // Internal buses
   // ********************
   gpu_wb_if  wb_bus ();
   mem_req_if mem_bus ();
   kbd_if     kbd_bus ();

   z80_cycle_ctrl u_ctrl (
      .GPU_CLK   (GPU_CLK),
      .arst_n    (arst_n),
      .m1_n      (z80_m1_n),
      .mreq_n    (z80_mreq_n),
      .iorq_n    (z80_iorq_n),
      .rd_n      (z80_rd_n),
      .wr_n      (z80_wr_n),
      .addr      (z80_addr),
      .wdata     (z80_wdata),
      .rdata     (z80_rdata),
      .rdata_ena (z80_rdata_ena),
      .dir       (z80_245_dir),
      .oe_n      (z80_245_oe_n),
      .wait_n    (z80_wait_n),
      .mem       (mem_bus.ctrl),
      .kbd       (kbd_bus.ctrl)
   );

   gpu_mem_port u_mem (.GPU_CLK(GPU_CLK), .arst_n(arst_n), .req(mem_bus.port), .wb(wb_bus.master));

   gpu_ram u_ram (.GPU_CLK(GPU_CLK), .arst_n(arst_n), .wb(wb_bus.slave));

   kbd_io_port u_kbd (
      .GPU_CLK (GPU_CLK),
      .arst_n  (arst_n),
      .ps2_rdy (ps2_rdy),
      .ps2_dat (ps2_dat),
      .iei     (z80_iei),
      .int_req (z80_int_req),
      .ieo     (z80_ieo),
      .kbd     (kbd_bus.port)
   );

endmodule

//--- hdl/z80_bus_pkg.sv
package z80_bus_pkg;

   // ********************
   // Host cycle kinds
   // ********************

   typedef enum logic [2:0] {
      CYC_NONE    = 3'd0,             // No qualifying strobes
      CYC_MEM_WR  = 3'd1,             // MREQ + WR inside the GPU window
      CYC_MEM_RD  = 3'd2,             // MREQ + RD inside the GPU window
      CYC_IO_DATA = 3'd3,             // IORQ + RD on the keyboard data port
      CYC_IO_STAT = 3'd4,             // IORQ + RD on the keyboard status port
      CYC_IO_CTRL = 3'd5,             // IORQ + WR on the keyboard control port
      CYC_INTA    = 3'd6              // M1 + IORQ while our request is up
   } bus_cycle_e;

   // ********************
   // Controller FSM
   // ********************

   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,                // Waiting for a decoded cycle
      ST_MEM   = 3'd1,                // Memory request out, waiting for done
      ST_TURN  = 3'd2,                // 245 turning toward the host
      ST_DRIVE = 3'd3,                // Read data loaded, release WAIT
      ST_HOLD  = 3'd4                 // Waiting for the host strobes to rise
   } ctrl_state_e;

   typedef struct packed {
      logic [5:0] rsvd;               // Always zero
      logic       int_en;             // Interrupt enable echo
      logic       avail;              // Character available
   } kbd_stat_t;

endpackage

//--- hdl/z80_cycle_ctrl.sv
`include "z80_bridge_defs.svh"

module z80_cycle_ctrl (
   input  logic        GPU_CLK,
   input  logic        arst_n,
   input  logic        m1_n,
   input  logic        mreq_n,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [21:0] addr,
   input  logic [7:0]  wdata,
   output logic [7:0]  rdata,         // Host read data register
   output logic        rdata_ena,     // Drive the FPGA data pins
   output logic        dir,           // 245 direction, 1 = toward FPGA
   output logic        oe_n,          // 245 enable
   output logic        wait_n,        // Z80 WAIT
   mem_req_if.ctrl     mem,
   kbd_if.ctrl         kbd
);
   import z80_bus_pkg::*;

   bus_cycle_e  cyc_d;                // Decode of the raw strobes
   bus_cycle_e  cyc_q;                // Sampled decode
   bus_cycle_e  cur_q;                // Kind of the cycle being served
   ctrl_state_e state_q;
   logic [2:0]  dly_q;                // 245 turnaround count
   logic        turn_done;
   logic        hold_end;

   // ********************
   // Strobe decode
   // ********************
   always_comb begin
      cyc_d = CYC_NONE;
      if (!mreq_n && m1_n && addr[21:19] == `MEMORY_RANGE) begin
         if (!wr_n)
            cyc_d = CYC_MEM_WR;
         else if (!rd_n)
            cyc_d = CYC_MEM_RD;
      end else if (!iorq_n && m1_n) begin
         if (!rd_n && addr[7:0] == `IO_DATA)
            cyc_d = CYC_IO_DATA;
         else if (!rd_n && addr[7:0] == `IO_STAT)
            cyc_d = CYC_IO_STAT;
         else if (!wr_n && addr[7:0] == `IO_CTRL)
            cyc_d = CYC_IO_CTRL;
      end else if (!iorq_n && !m1_n && kbd.int_pending) begin
         cyc_d = CYC_INTA;            // Only answer when we asked
      end
   end

   assign turn_done = (state_q == ST_TURN) && (dly_q == 3'(`TURN_DLY - 1));
   assign hold_end  = (state_q == ST_HOLD) && (cyc_q == CYC_NONE);   // Strobes back high

   assign kbd.rd_data_done = hold_end && (cur_q == CYC_IO_DATA);
   assign kbd.inta_end     = hold_end && (cur_q == CYC_INTA);
   assign kbd.ctrl_wr      = (state_q == ST_IDLE) && (cyc_q == CYC_IO_CTRL);
   assign kbd.ctrl_wdata   = wdata;

   // ********************
   // Cycle FSM
   // ********************
   always_ff @(posedge GPU_CLK or negedge arst_n) begin
      if (!arst_n) begin
         cyc_q     <= CYC_NONE;
         cur_q     <= CYC_NONE;
         state_q   <= ST_IDLE;
         dly_q     <= '0;
         mem.req   <= 1'b0;
         rdata_ena <= 1'b0;
         dir       <= 1'b1;
         oe_n      <= 1'b1;
         wait_n    <= 1'b1;
      end else begin
         cyc_q   <= cyc_d;
         mem.req <= 1'b0;             // Pulse only
         case (state_q)
            ST_IDLE: if (cyc_q != CYC_NONE) begin
               cur_q <= cyc_q;
               oe_n  <= 1'b0;         // Open the translator
               case (cyc_q)
                  CYC_MEM_WR: begin
                     mem.req <= 1'b1;
                     wait_n  <= 1'b0;
                     state_q <= ST_MEM;
                  end
                  CYC_MEM_RD: begin
                     mem.req   <= 1'b1;
                     wait_n    <= 1'b0;
                     dir       <= 1'b0;   // Toward the host
                     rdata_ena <= 1'b1;
                     state_q   <= ST_MEM;
                  end
                  CYC_IO_CTRL: state_q <= ST_HOLD;   // No WAIT needed
                  default: begin                    // I/O read or acknowledge
                     wait_n    <= 1'b0;
                     dir       <= 1'b0;
                     rdata_ena <= 1'b1;
                     dly_q     <= '0;
                     state_q   <= ST_TURN;
                  end
               endcase
            end
            ST_MEM: if (mem.done) begin
               wait_n  <= 1'b1;       // Data register loads on this edge too
               state_q <= ST_HOLD;
            end
            ST_TURN: begin
               dly_q <= dly_q + 3'd1;
               if (turn_done)
                  state_q <= ST_DRIVE;
            end
            ST_DRIVE: begin
               wait_n  <= 1'b1;
               state_q <= ST_HOLD;
            end
            ST_HOLD: if (hold_end) begin
               dir       <= 1'b1;
               rdata_ena <= 1'b0;
               oe_n      <= 1'b1;
               state_q   <= ST_IDLE;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Request payload and host read data
   always_ff @(posedge GPU_CLK) begin
      if (state_q == ST_IDLE) begin
         mem.addr  <= addr[18:0];     // Offset inside the window
         mem.we    <= (cyc_q == CYC_MEM_WR);
         mem.wdata <= wdata;
      end
      if (state_q == ST_MEM && mem.done && cur_q == CYC_MEM_RD)
         rdata <= mem.rdata;
      if (turn_done) begin
         case (cur_q)
            CYC_IO_DATA: rdata <= kbd.char;
            CYC_IO_STAT: rdata <= kbd.stat;
            default:     rdata <= `INT_VEC;
         endcase
      end
   end

endmodule

//--- include/z80_bridge_defs.svh
`ifndef Z80_BRIDGE_DEFS_SVH
`define Z80_BRIDGE_DEFS_SVH

// ********************
// Address map
// ********************

`define MEMORY_RANGE  3'b010          // addr[21:19] of the 512 KB socket window
`define MEM_SIZE_BITS 15              // 32 KB of populated GPU RAM
`define BANK_ID_ADDR  18'h17FFF       // addr[21:4] of the 16 byte bank-ID block

// ********************
// Keyboard I/O ports
// ********************

`define IO_DATA       8'd240          // Character read
`define IO_STAT       8'd241          // Status read
`define IO_CTRL       8'd242          // Control write, bit 0 enables interrupts

`define INT_VEC       8'h30           // Vector returned on acknowledge
`define TURN_DLY      4               // GPU_CLK cycles for the 245 to settle

`endif

//--- verif/z80_bridge_props.sv
module z80_bridge_props (
   input logic                   GPU_CLK,
   input logic                   arst_n,
   input logic                   wb_cyc,
   input logic                   wb_stb,
   input logic                   wb_we,
   input gpu_mem_pkg::gpu_addr_t wb_adr,
   input gpu_mem_pkg::gpu_data_t wb_dat_w,
   input logic                   wb_ack,
   input logic                   m1_n,
   input logic                   mreq_n,
   input logic                   iorq_n,
   input logic                   rd_n,
   input logic                   wr_n,
   input logic                   rdata_ena,
   input logic                   dir,
   input logic                   oe_n,
   input logic                   wait_n,
   input logic                   int_req,
   input logic                   ieo
);
   int fail_cnt = 0;                  // Count of failed properties

   // ********************
   // Wishbone classic
   // ********************
   assert property (@(posedge GPU_CLK) disable iff (!arst_n) wb_stb |-> wb_cyc)
      else begin fail_cnt++; $error("Wishbone stb without cyc"); end

   assert property (@(posedge GPU_CLK) disable iff (!arst_n)
                    (wb_stb && !wb_ack) |=> wb_stb && $stable(wb_adr) && $stable(wb_we)
                    && $stable(wb_dat_w))
      else begin fail_cnt++; $error("Wishbone request changed before ack"); end

   assert property (@(posedge GPU_CLK) disable iff (!arst_n) wb_ack |-> wb_stb)
      else begin fail_cnt++; $error("Wishbone ack without a strobe"); end

   assert property (@(posedge GPU_CLK) disable iff (!arst_n) wb_ack |=> !wb_cyc)
      else begin fail_cnt++; $error("Wishbone cyc still high after ack"); end

   // ********************
   // Host side
   // ********************
   assert property (@(posedge GPU_CLK) disable iff (!arst_n) rdata_ena |-> (!dir && !oe_n))
      else begin fail_cnt++; $error("Data driven while the 245 is not open to the host"); end

   assert property (@(posedge GPU_CLK) disable iff (!arst_n) int_req |-> !ieo)
      else begin fail_cnt++; $error("IEO high while an interrupt is requested"); end

   // Idle bus must never be held
   assert property (@(posedge GPU_CLK) disable iff (!arst_n)
                    (m1_n && mreq_n && iorq_n && rd_n && wr_n) |-> wait_n)
      else begin fail_cnt++; $error("WAIT low with all host strobes high"); end

endmodule

bind z80_bridge_top z80_bridge_props u_props (
   .GPU_CLK   (GPU_CLK),
   .arst_n    (arst_n),
   .wb_cyc    (wb_bus.cyc),
   .wb_stb    (wb_bus.stb),
   .wb_we     (wb_bus.we),
   .wb_adr    (wb_bus.adr),
   .wb_dat_w  (wb_bus.dat_w),
   .wb_ack    (wb_bus.ack),
   .m1_n      (z80_m1_n),
   .mreq_n    (z80_mreq_n),
   .iorq_n    (z80_iorq_n),
   .rd_n      (z80_rd_n),
   .wr_n      (z80_wr_n),
   .rdata_ena (z80_rdata_ena),
   .dir       (z80_245_dir),
   .oe_n      (z80_245_oe_n),
   .wait_n    (z80_wait_n),
   .int_req   (z80_int_req),
   .ieo       (z80_ieo)
);

//--- verif/z80_bridge_tb.sv
`include "z80_bridge_defs.svh"

module z80_bridge_tb;

   logic        GPU_CLK = 1'b0;
   logic        arst_n;
   logic        z80_m1_n, z80_mreq_n, z80_iorq_n, z80_rd_n, z80_wr_n;   // Host strobes
   logic        z80_iei, ps2_rdy;
   logic [21:0] z80_addr;
   logic [7:0]  z80_wdata, ps2_dat;
   logic [7:0]  z80_rdata;
   logic        z80_rdata_ena, z80_245_dir, z80_245_oe_n, z80_wait_n, z80_int_req, z80_ieo;

   logic [31:0] seed = 32'h0f3db893;
   logic [7:0]  ref_mem [2**`MEM_SIZE_BITS];   // Reference GPU RAM
   logic [7:0]  bank_table [16] = '{8'h09, 8'h03, 8'h47, 8'h50, 8'h55, 8'h20, 8'h45, 8'h50,
                                    8'h34, 8'h43, 8'h45, 8'h36, 8'h00, 8'hFF, 8'hFF, 8'hFF};
   logic [21:0] wr_addr [$];                   // Written in the random pass

   always #4 GPU_CLK = ~GPU_CLK;

   z80_bridge_top uut (.*);

   // ********************
   // Helpers
   // ********************
   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;   // LCG step
      return seed;
   endfunction

   // What a window read should return
   function automatic logic [7:0] expected_read(input logic [21:0] a);
      if (a[18:`MEM_SIZE_BITS] == '0)
         return ref_mem[a[`MEM_SIZE_BITS-1:0]];
      else if (a[21:4] == `BANK_ID_ADDR)
         return bank_table[a[3:0]];
      return 8'hFF;                   // Unpopulated
   endfunction

   task automatic stop_on_failure();
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
      assert (actual === expected) else begin
         $display("Error %s: expected %02h, actual %02h", name, expected, actual);
         stop_on_failure();
      end
   endtask

   // One host cycle with strb as {m1_n, mreq_n, iorq_n, rd_n, wr_n}
   task automatic host_cycle(input string name, input logic [21:0] a, input logic [7:0] d,
                             input logic [4:0] strb, output logic [7:0] rd);
      int waited;
      @(posedge GPU_CLK);
      z80_addr  <= a;
      z80_wdata <= d;
      {z80_m1_n, z80_mreq_n, z80_iorq_n, z80_rd_n, z80_wr_n} <= strb;
      repeat (2) @(posedge GPU_CLK);                  // Decode and then WAIT low
      waited = 0;
      @(negedge GPU_CLK);
      while (!z80_wait_n) begin
         waited++;
         if (waited > 40) begin
            $display("Timeout in %s: WAIT never returned high", name);
            stop_on_failure();
         end
         @(negedge GPU_CLK);
      end
      rd = z80_rdata;
      if (!strb[1] || !strb[4])                       // Read or acknowledge
         check_byte({name, " rdata_ena"}, 8'h01, 8'(z80_rdata_ena));
      else
         check_byte({name, " rdata_ena"}, 8'h00, 8'(z80_rdata_ena));
      @(posedge GPU_CLK);
      {z80_m1_n, z80_mreq_n, z80_iorq_n, z80_rd_n, z80_wr_n} <= 5'b11111;
      repeat (3) @(posedge GPU_CLK);                  // FSM back to idle
   endtask

   task automatic mem_write(input logic [21:0] a, input logic [7:0] d);
      logic [7:0] ignored;
      host_cycle("mem_write", a, d, 5'b10110, ignored);
   endtask

   task automatic mem_read(input logic [21:0] a, output logic [7:0] rd);
      host_cycle("mem_read", a, 8'h00, 5'b10101, rd);
   endtask

   task automatic io_read(input logic [7:0] port, output logic [7:0] rd);
      host_cycle("io_read", {14'd0, port}, 8'h00, 5'b11001, rd);
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] d);
      logic [7:0] ignored;
      host_cycle("io_write", {14'd0, port}, d, 5'b11010, ignored);
   endtask

   task automatic inta(output logic [7:0] rd);
      host_cycle("inta", 22'd0, 8'h00, 5'b01011, rd);  // M1 with IORQ
   endtask

   // Memory read outside the window leaves the bridge off the bus
   task automatic outside_read(input logic [21:0] a);
      @(posedge GPU_CLK);
      z80_addr   <= a;
      z80_mreq_n <= 1'b0;
      z80_rd_n   <= 1'b0;
      repeat (8) begin
         @(negedge GPU_CLK);
         check_byte("outside rdata_ena", 8'h00, 8'(z80_rdata_ena));
      end
      @(posedge GPU_CLK);
      z80_mreq_n <= 1'b1;
      z80_rd_n   <= 1'b1;
   endtask

   task automatic press_key(input logic [7:0] d);
      @(posedge GPU_CLK);
      ps2_dat <= d;
      ps2_rdy <= 1'b1;
      @(posedge GPU_CLK);
      ps2_rdy <= 1'b0;
      repeat (2) @(posedge GPU_CLK);
   endtask

   task automatic wait_int_req();
      int waited;
      waited = 0;
      @(negedge GPU_CLK);
      while (!z80_int_req) begin
         waited++;
         if (waited > 20) begin
            $display("Timeout: interrupt request never raised after a key");
            stop_on_failure();
         end
         @(negedge GPU_CLK);
      end
   endtask

   always @(negedge GPU_CLK) begin
      if (uut.u_props.fail_cnt != 0) begin
         $display("A bound assertion on the bridge failed");
         stop_on_failure();
      end
   end

   // ********************
   // Test sequence
   // ********************
   initial begin
      logic [7:0]  rd;
      logic [31:0] r;
      logic [21:0] a;
      logic [21:0] low_a;
      arst_n = 1'b0;
      {z80_m1_n, z80_mreq_n, z80_iorq_n, z80_rd_n, z80_wr_n} = 5'b11111;
      z80_iei   = 1'b0;
      ps2_rdy   = 1'b0;
      ps2_dat   = 8'h00;
      z80_addr  = '0;
      z80_wdata = 8'h00;
      repeat (3) @(posedge GPU_CLK);
      @(negedge GPU_CLK);
      check_byte("reset ieo low", 8'h00, 8'(z80_ieo));   // Follows IEI under reset
      @(posedge GPU_CLK);
      z80_iei <= 1'b1;
      repeat (3) @(posedge GPU_CLK);
      @(negedge GPU_CLK);
      check_byte("reset ieo high", 8'h01, 8'(z80_ieo));
      @(posedge GPU_CLK);
      arst_n <= 1'b1;
      @(negedge GPU_CLK);
      check_byte("idle rdata_ena", 8'h00, 8'(z80_rdata_ena));
      check_byte("idle 245 dir", 8'h01, 8'(z80_245_dir));
      check_byte("idle 245 oe_n", 8'h01, 8'(z80_245_oe_n));
      check_byte("idle wait_n", 8'h01, 8'(z80_wait_n));
      check_byte("idle int_req", 8'h00, 8'(z80_int_req));

      repeat (24) begin                              // Random RAM traffic
         r = next_rand();
         a = {`MEMORY_RANGE, 19'(r[`MEM_SIZE_BITS-1:0])};
         ref_mem[r[`MEM_SIZE_BITS-1:0]] = r[23:16];
         wr_addr.push_back(a);
         mem_write(a, r[23:16]);
      end
      foreach (wr_addr[i]) begin
         mem_read(wr_addr[i], rd);
         check_byte("ram readback", expected_read(wr_addr[i]), rd);
      end

      for (int i = 0; i < 16; i++) begin
         mem_read({`BANK_ID_ADDR, 4'(i)}, rd);
         check_byte("bank id", bank_table[i], rd);
      end
      repeat (6) begin                               // Above RAM and outside the window
         r = next_rand();
         a = {`MEMORY_RANGE, r[18:0] | 19'h08000};
         low_a = {`MEMORY_RANGE, 19'(a[`MEM_SIZE_BITS-1:0])};   // RAM byte the write aliases
         ref_mem[a[`MEM_SIZE_BITS-1:0]] = ~r[31:24];
         mem_write(low_a, ~r[31:24]);
         mem_write(a, r[31:24]);
         mem_read(a, rd);
         check_byte("above ram", expected_read(a), rd);
         mem_read(low_a, rd);
         check_byte("dropped write", expected_read(low_a), rd);
         outside_read({3'b000, r[18:0]});
      end

      r = next_rand();                               // Polled keyboard
      press_key(r[7:0]);
      io_read(`IO_STAT, rd);
      check_byte("polled status", 8'h01, rd);
      io_read(`IO_DATA, rd);
      check_byte("polled data", r[7:0], rd);
      io_read(`IO_STAT, rd);
      check_byte("status after read", 8'h00, rd);
      check_byte("polled int_req", 8'h00, 8'(z80_int_req));

      io_write(`IO_CTRL, 8'h01);                     // Interrupt mode
      r = next_rand();
      press_key(r[7:0]);
      wait_int_req();
      check_byte("ieo while pending", 8'h00, 8'(z80_ieo));
      inta(rd);
      check_byte("interrupt vector", `INT_VEC, rd);
      @(negedge GPU_CLK);
      check_byte("int_req after inta", 8'h00, 8'(z80_int_req));
      check_byte("ieo after inta", 8'h01, 8'(z80_ieo));
      io_read(`IO_STAT, rd);
      check_byte("irq status", 8'h03, rd);
      io_read(`IO_DATA, rd);
      check_byte("irq data", r[7:0], rd);

      repeat (4) @(posedge GPU_CLK);
      if (uut.u_props.fail_cnt == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("A bound assertion on the bridge failed");
         stop_on_failure();
      end
   end

endmodule
